// ==== build.f ====
+incdir+include
source/muldiv_pkg.sv
source/muldiv_op_if.sv
source/mul_pipe.sv
source/div_iter.sv
source/mult_div.sv
source/muldiv_axil_regs.sv
source/muldiv_top.sv
bench/muldiv_tb.sv

// ==== bench/muldiv_tb.sv ====
`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_tb;
	import muldiv_pkg::*;

	localparam int TIMEOUT    = 200; // Cycles allowed for one AXI handshake
	localparam int POLL_LIMIT = 100;

	logic                      clk;
	logic                      arst_n;
	logic [`MULDIV_ADDR_W-1:0] awaddr;
	logic                      awvalid;
	logic                      awready;
	data_t                     wdata;
	logic [3:0]                wstrb;
	logic                      wvalid;
	logic                      wready;
	resp_t                     bresp;
	logic                      bvalid;
	logic                      bready;
	logic [`MULDIV_ADDR_W-1:0] araddr;
	logic                      arvalid;
	logic                      arready;
	data_t                     rdata;
	resp_t                     rresp;
	logic                      rvalid;
	logic                      rready;
	logic [31:0]               lfsr_q;

	muldiv_top i_dut (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
			report_failure($sformatf("Fail %s expected %h got %h", name, expected, actual));
	endtask

	task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
		if (actual !== expected)
			report_failure($sformatf("Fail %s expected %h got %h", name, expected, actual));
	endtask

	task automatic check_status(input data_t expected, input data_t actual);
		if (actual !== expected)
			report_failure($sformatf("Fail STATUS expected %h got %h", expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("Fail %s expected %h got %h", name, expected, actual));
	endtask

	// Taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_word(output data_t word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			word   = {word[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// Expected result per the RISC-V M rules, including divide by zero and overflow
	function automatic data_t ref_result(input funct3_t f, input data_t a, input data_t b);
		logic [63:0]        prod;
		logic signed [31:0] da;
		logic signed [31:0] db;
		logic signed [31:0] q;
		logic               overflow;
		da       = a;
		db       = b;
		overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		case (f)
			MUL, MULH: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			MULHSU:    prod = {{32{a[31]}}, a} * {32'b0, b};
			default:   prod = {32'b0, a} * {32'b0, b};
		endcase
		case (f)
			MUL:                 return prod[31:0];
			MULH, MULHSU, MULHU: return prod[63:32];
			DIV: begin
				if (b == '0)
					return '1;
				if (overflow)
					return 32'h8000_0000;
				q = da / db;
				return q;
			end
			DIVU:    return (b == '0) ? '1 : a / b;
			REM: begin
				if (b == '0)
					return a;
				if (overflow)
					return '0;
				q = da % db; // Sign follows the dividend
				return q;
			end
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	function automatic data_t make_cmd(input funct3_t f, input logic [6:0] opcode,
			input logic [6:0] funct7);
		instr_t instr;
		instr.funct7 = funct7;
		instr.rs2    = 5'd2;
		instr.rs1    = 5'd1;
		instr.funct3 = f;
		instr.rd     = 5'd3;
		instr.opcode = opcode;
		return instr;
	endfunction

	// Holds bready low for stall cycles after bvalid and checks the response stays put
	task automatic axi_write(input logic [`MULDIV_ADDR_W-1:0] addr, input data_t data,
			input int stall, output resp_t resp);
		int cycles;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wvalid  <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout waiting for the write address and data to be accepted");
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout waiting for the write response");
		end while (!bvalid);
		resp = bresp;
		repeat (stall) begin
			@(posedge clk);
			if (!bvalid)
				report_failure("Write response dropped while bready was low");
			check_resp("bresp", resp, bresp);
			check_flag("awready", 1'b0, awready);
			check_flag("wready", 1'b0, wready);
		end
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`MULDIV_ADDR_W-1:0] addr, input int stall,
			output data_t data, output resp_t resp);
		int cycles;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout waiting for the read address to be accepted");
		end while (!arready);
		arvalid <= 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout waiting for the read data");
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		repeat (stall) begin
			@(posedge clk);
			if (!rvalid)
				report_failure("Read data dropped while rready was low");
			check_data("rdata", data, rdata);
			check_resp("rresp", resp, rresp);
			check_flag("arready", 1'b0, arready);
		end
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_check(input logic [`MULDIV_ADDR_W-1:0] addr, input data_t data,
			input resp_t expected);
		resp_t resp;
		axi_write(addr, data, 0, resp);
		check_resp("bresp", expected, resp);
	endtask

	task automatic read_check(input logic [`MULDIV_ADDR_W-1:0] addr, input data_t expected,
			input resp_t exp_resp, input int stall);
		data_t data;
		resp_t resp;
		axi_read(addr, stall, data, resp);
		check_resp("rresp", exp_resp, resp);
		check_data("rdata", expected, data);
	endtask

	task automatic wait_done();
		data_t status;
		resp_t resp;
		int    polls;
		polls = 0;
		do begin
			axi_read(`MULDIV_REG_STATUS, 0, status, resp);
			check_resp("rresp", OKAY, resp);
			polls++;
			if (polls > POLL_LIMIT)
				report_failure("Timeout waiting for STATUS to show done");
		end while (!status[`MULDIV_STATUS_DONE]);
		check_status(32'h2, status);
	endtask

	task automatic run_op_expect(input funct3_t f, input data_t a, input data_t b,
			input data_t expected);
		write_check(`MULDIV_REG_OPA, a, OKAY);
		write_check(`MULDIV_REG_OPB, b, OKAY);
		write_check(`MULDIV_REG_CMD, make_cmd(f, OPCODE_OP, FUNCT7_MULDIV), OKAY);
		wait_done();
		read_check(`MULDIV_REG_RESULT, expected, OKAY, 0);
	endtask

	task automatic run_op(input funct3_t f, input data_t a, input data_t b);
		run_op_expect(f, a, b, ref_result(f, a, b));
	endtask

	task automatic reset_values_and_readback();
		data_t word;
		@(posedge clk);
		check_flag("awready", 1'b1, awready);
		check_flag("wready", 1'b1, wready);
		check_flag("arready", 1'b1, arready);
		check_flag("bvalid", 1'b0, bvalid);
		check_flag("rvalid", 1'b0, rvalid);
		read_check(`MULDIV_REG_STATUS, '0, OKAY, 0);
		read_check(`MULDIV_REG_RESULT, '0, OKAY, 0);
		random_word(word);
		write_check(`MULDIV_REG_OPA, word, OKAY);
		read_check(`MULDIV_REG_OPA, word, OKAY, 0);
		random_word(word);
		write_check(`MULDIV_REG_OPB, word, OKAY);
		read_check(`MULDIV_REG_OPB, word, OKAY, 0);
	endtask

	task automatic sweep_all_funct3();
		data_t edges [4];
		data_t a;
		data_t b;
		edges = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000};
		for (int k = 0; k < 8; k++) begin
			for (int n = 0; n < 20; n++) begin
				random_word(a);
				random_word(b);
				run_op(funct3_t'(k), a, b);
			end
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++)
					run_op(funct3_t'(k), edges[i], edges[j]);
			end
		end
	endtask

	task automatic div_corner_cases();
		run_op_expect(DIV, 32'h1234_5678, 32'h0, 32'hFFFF_FFFF);
		run_op_expect(DIVU, 32'h1234_5678, 32'h0, 32'hFFFF_FFFF);
		run_op_expect(REM, 32'h1234_5678, 32'h0, 32'h1234_5678);
		run_op_expect(REMU, 32'hF234_5678, 32'h0, 32'hF234_5678);
		run_op_expect(DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
		run_op_expect(REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0);
		run_op_expect(DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0); // No overflow when unsigned
		run_op_expect(REMU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
	endtask

	task automatic illegal_and_busy_cmd();
		data_t status;
		resp_t resp;
		run_op_expect(MUL, 32'h0000_1234, 32'h0000_0010, 32'h0001_2340);
		write_check(`MULDIV_REG_CMD, make_cmd(MULHU, 7'b0010011, FUNCT7_MULDIV), OKAY);
		axi_read(`MULDIV_REG_STATUS, 0, status, resp);
		check_status(32'h4, status);
		read_check(`MULDIV_REG_RESULT, 32'h0001_2340, OKAY, 0);
		write_check(`MULDIV_REG_CMD, make_cmd(MULH, OPCODE_OP, 7'b0100000), OKAY);
		axi_read(`MULDIV_REG_STATUS, 0, status, resp);
		check_status(32'h4, status);
		read_check(`MULDIV_REG_RESULT, 32'h0001_2340, OKAY, 0);
		write_check(`MULDIV_REG_OPA, 32'hDEAD_BEEF, OKAY);
		write_check(`MULDIV_REG_OPB, 32'h0000_0007, OKAY);
		write_check(`MULDIV_REG_CMD, make_cmd(DIV, OPCODE_OP, FUNCT7_MULDIV), OKAY);
		write_check(`MULDIV_REG_CMD, make_cmd(MUL, OPCODE_OP, FUNCT7_MULDIV), SLVERR);
		wait_done();
		read_check(`MULDIV_REG_RESULT, ref_result(DIV, 32'hDEAD_BEEF, 32'h7), OKAY, 0);
	endtask

	task automatic bad_address_access();
		read_check(`MULDIV_REG_CMD, '0, SLVERR, 0);
		read_check(5'h14, '0, SLVERR, 0);
		write_check(`MULDIV_REG_RESULT, 32'h5555_AAAA, SLVERR);
		write_check(`MULDIV_REG_STATUS, 32'h0000_0007, SLVERR);
		write_check(5'h1C, 32'h1234_5678, SLVERR);
	endtask

	task automatic stalled_responses();
		data_t status;
		resp_t resp;
		axi_write(`MULDIV_REG_OPA, 32'h8765_4321, 5, resp);
		check_resp("bresp", OKAY, resp);
		axi_write(`MULDIV_REG_OPB, 32'hFFFF_FFF3, 5, resp);
		check_resp("bresp", OKAY, resp);
		axi_write(`MULDIV_REG_CMD, make_cmd(REM, OPCODE_OP, FUNCT7_MULDIV), 6, resp);
		check_resp("bresp", OKAY, resp);
		axi_read(`MULDIV_REG_STATUS, 5, status, resp);
		check_resp("rresp", OKAY, resp);
		check_status(32'h1, status); // Division still running
		wait_done();
		read_check(`MULDIV_REG_RESULT, ref_result(REM, 32'h8765_4321, 32'hFFFF_FFF3), OKAY, 4);
	endtask

	initial begin
		arst_n  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = 4'hF;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		lfsr_q  = 32'h291;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		reset_values_and_readback();
		sweep_all_funct3();
		div_corner_cases();
		illegal_and_busy_cmd();
		bad_address_access();
		stalled_responses();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== source/muldiv_top.sv ====
`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [`MULDIV_ADDR_W-1:0] awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  muldiv_pkg::data_t         wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output muldiv_pkg::resp_t         bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`MULDIV_ADDR_W-1:0] araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output muldiv_pkg::data_t         rdata,
	output muldiv_pkg::resp_t         rresp,
	output logic                      rvalid,
	input  logic                      rready
);

	muldiv_op_if op_bus ();

	muldiv_axil_regs i_regs (
		.*,
		.op (op_bus)
	);

	mult_div i_mult_div (
		.clk    (clk),
		.arst_n (arst_n),
		.op     (op_bus)
	);

endmodule

// ==== source/muldiv_axil_regs.sv ====
`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_axil_regs (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [`MULDIV_ADDR_W-1:0] awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  muldiv_pkg::data_t         wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output muldiv_pkg::resp_t         bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`MULDIV_ADDR_W-1:0] araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output muldiv_pkg::data_t         rdata,
	output muldiv_pkg::resp_t         rresp,
	output logic                      rvalid,
	input  logic                      rready,
	muldiv_op_if.ctrl                 op
);
	import muldiv_pkg::*;

	data_t   opa_q;
	data_t   opb_q;
	data_t   result_q;
	funct3_t funct3_q;
	logic    start_q;
	logic    done_q;
	logic    illegal_q;
	logic    bvalid_q;
	resp_t   bresp_q;
	logic    rvalid_q;
	resp_t   rresp_q;
	data_t   rdata_q;
	logic    busy_any;
	logic    wr_fire;
	logic    rd_fire;
	logic    cmd_ok;
	instr_t  cmd;
	data_t   rd_word;
	logic    rd_err;

	function automatic data_t merge_bytes(data_t old_word, data_t new_word, logic [3:0] strb);
		data_t merged;
		merged = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				merged[8*i +: 8] = new_word[8*i +: 8];
		end
		return merged;
	endfunction

	assign busy_any = start_q || op.busy; // Covers the cycle between CMD accept and unit busy
	assign awready  = !bvalid_q && (awvalid == wvalid); // Address and data are taken together
	assign wready   = awready;
	assign wr_fire  = awvalid && wvalid && awready;
	assign arready  = !rvalid_q;
	assign rd_fire  = arvalid && arready;
	assign cmd      = wdata;
	assign cmd_ok   = (cmd.opcode == OPCODE_OP) && (cmd.funct7 == FUNCT7_MULDIV);

	always_comb begin
		rd_err = 1'b0;
		case (araddr)
			`MULDIV_REG_OPA:    rd_word = opa_q;
			`MULDIV_REG_OPB:    rd_word = opb_q;
			`MULDIV_REG_RESULT: rd_word = result_q;
			`MULDIV_REG_STATUS: rd_word = {29'b0, illegal_q, done_q, busy_any};
			default: begin
				rd_word = '0;
				rd_err  = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid_q  <= 1'b0;
			bresp_q   <= OKAY;
			rvalid_q  <= 1'b0;
			rresp_q   <= OKAY;
			start_q   <= 1'b0;
			done_q    <= 1'b0;
			illegal_q <= 1'b0;
			result_q  <= '0;
		end else begin
			start_q <= 1'b0;
			if (bvalid_q && bready)
				bvalid_q <= 1'b0;
			if (rvalid_q && rready)
				rvalid_q <= 1'b0;
			if (wr_fire) begin
				bvalid_q <= 1'b1;
				bresp_q  <= OKAY;
				case (awaddr)
					`MULDIV_REG_OPA, `MULDIV_REG_OPB: done_q <= 1'b0;
					`MULDIV_REG_CMD: begin
						if (busy_any) begin
							bresp_q <= SLVERR;
						end else begin
							done_q    <= 1'b0;
							illegal_q <= !cmd_ok; // Illegal word still gets OKAY
							start_q   <= cmd_ok;
						end
					end
					default: bresp_q <= SLVERR;
				endcase
			end
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				rresp_q  <= rd_err ? SLVERR : OKAY;
			end
			if (op.done) begin
				result_q <= op.result;
				done_q   <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && awaddr == `MULDIV_REG_OPA)
			opa_q <= merge_bytes(opa_q, wdata, wstrb);
		if (wr_fire && awaddr == `MULDIV_REG_OPB)
			opb_q <= merge_bytes(opb_q, wdata, wstrb);
		if (wr_fire && awaddr == `MULDIV_REG_CMD && !busy_any && cmd_ok)
			funct3_q <= cmd.funct3;
		if (rd_fire)
			rdata_q <= rd_word;
	end

	assign bvalid    = bvalid_q;
	assign bresp     = bresp_q;
	assign rvalid    = rvalid_q;
	assign rresp     = rresp_q;
	assign rdata     = rdata_q;
	assign op.start  = start_q;
	assign op.funct3 = funct3_q;
	assign op.a      = opa_q; // Stable in the start cycle since bvalid blocks writes
	assign op.b      = opb_q;

	assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge clk) disable iff (!arst_n) op.start |-> !op.busy);

endmodule

// ==== source/mult_div.sv ====
`timescale 1ns/1ps

module mult_div (
	input logic       clk,
	input logic       arst_n,
	muldiv_op_if.unit op
);
	import muldiv_pkg::*;

	logic        a_signed;
	logic        b_signed;
	logic [32:0] a_ext;
	logic [32:0] b_ext;
	logic        is_mul;
	logic        div_zero;
	logic        div_ovf;
	logic        special;
	logic        mul_start;
	logic        mul_valid;
	logic [65:0] product;
	logic        div_start;
	logic        div_busy;
	logic        div_done;
	logic [32:0] quotient;
	logic [32:0] remain;
	funct3_t     funct3_q;
	data_t       a_q;
	data_t       b_q;
	logic        busy_q;
	logic        special_q;
	data_t       special_res;
	data_t       result;

	// MULHSU takes rs1 as signed and rs2 as unsigned
	assign a_signed = (op.funct3 != MULHU) && (op.funct3 != DIVU) && (op.funct3 != REMU);
	assign b_signed = (op.funct3 == MUL) || (op.funct3 == MULH) ||
		(op.funct3 == DIV) || (op.funct3 == REM);
	assign a_ext = {a_signed & op.a[31], op.a};
	assign b_ext = {b_signed & op.b[31], op.b};

	assign is_mul    = !op.funct3[2];
	assign div_zero  = (op.b == '0);
	assign div_ovf   = b_signed && (op.a == 32'h8000_0000) && (op.b == '1);
	assign special   = !is_mul && (div_zero || div_ovf); // Resolved here without the divider
	assign mul_start = op.start && is_mul;
	assign div_start = op.start && !is_mul && !special;

	mul_pipe i_mul_pipe (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (mul_start),
		.a         (a_ext),
		.b         (b_ext),
		.out_valid (mul_valid),
		.product   (product)
	);

	div_iter i_div_iter (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (div_start),
		.numer    (a_ext),
		.denom    (b_ext),
		.busy     (div_busy),
		.done     (div_done),
		.quotient (quotient),
		.remain   (remain)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q    <= 1'b0;
			special_q <= 1'b0;
		end else begin
			special_q <= op.start && special;
			if (op.start)
				busy_q <= 1'b1;
			else if (op.done)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (op.start) begin
			funct3_q <= op.funct3;
			a_q      <= op.a;
			b_q      <= op.b;
		end
	end

	// Divide by zero wins over overflow, REM variants have funct3 bit 1 set
	always_comb begin
		if (b_q == '0)
			special_res = funct3_q[1] ? a_q : '1;
		else
			special_res = funct3_q[1] ? '0 : 32'h8000_0000;
	end

	always_comb begin
		if (special_q) begin
			result = special_res;
		end else begin
			unique case (funct3_q)
				MUL:                 result = product[31:0];
				MULH, MULHSU, MULHU: result = product[63:32];
				DIV, DIVU:           result = quotient[31:0];
				REM, REMU:           result = remain[31:0];
			endcase
		end
	end

	assign op.busy   = busy_q;
	assign op.done   = mul_valid || div_done || special_q;
	assign op.result = result;

	assert property (@(posedge clk) disable iff (!arst_n) !(op.done && op.start));
	assert property (@(posedge clk) disable iff (!arst_n) div_busy |-> busy_q);

endmodule

// ==== source/div_iter.sv ====
`timescale 1ns/1ps

module div_iter (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        start,
	input  logic [32:0] numer,
	input  logic [32:0] denom,
	output logic        busy,
	output logic        done,
	output logic [32:0] quotient,
	output logic [32:0] remain
);
	logic [5:0]  count_q;
	logic        busy_q;
	logic        done_q;
	logic [32:0] quo_q;
	logic [32:0] rem_q;
	logic [32:0] den_q;
	logic        neg_quo_q;
	logic        neg_rem_q;
	logic [33:0] rem_shift;
	logic [33:0] rem_diff;
	logic        fits;

	assign rem_shift = {rem_q, quo_q[32]}; // Next dividend bit enters the partial remainder
	assign rem_diff  = rem_shift - {1'b0, den_q};
	assign fits      = rem_shift >= {1'b0, den_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			count_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				busy_q  <= 1'b1;
				count_q <= 6'd33;
			end else if (done_q) begin
				busy_q <= 1'b0;
			end else if (count_q != '0) begin
				count_q <= count_q - 6'd1;
				done_q  <= (count_q == 6'd1);
			end
		end
	end

	// Magnitudes are divided, signs are applied on the way out
	always_ff @(posedge clk) begin
		if (start) begin
			quo_q     <= numer[32] ? -numer : numer;
			rem_q     <= '0;
			den_q     <= denom[32] ? -denom : denom;
			neg_quo_q <= numer[32] ^ denom[32];
			neg_rem_q <= numer[32];
		end else if (count_q != '0) begin
			quo_q <= {quo_q[31:0], fits};
			rem_q <= fits ? rem_diff[32:0] : rem_shift[32:0];
		end
	end

	assign busy     = busy_q;
	assign done     = done_q;
	assign quotient = neg_quo_q ? -quo_q : quo_q;
	assign remain   = neg_rem_q ? -rem_q : rem_q; // Remainder follows the dividend sign

	assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy_q);

endmodule

// ==== source/mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_valid,
	input  logic [32:0] a,
	input  logic [32:0] b,
	output logic        out_valid,
	output logic [65:0] product
);
	logic               valid1_q;
	logic               valid2_q;
	logic signed [32:0] a_q;
	logic signed [32:0] b_q;
	logic signed [65:0] prod_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid1_q <= 1'b0;
			valid2_q <= 1'b0;
		end else begin
			valid1_q <= in_valid;
			valid2_q <= valid1_q;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			a_q <= a; // Operands already extended by the caller
			b_q <= b;
		end
		if (valid1_q)
			prod_q <= a_q * b_q;
	end

	assign out_valid = valid2_q;
	assign product   = prod_q;

endmodule

// ==== source/muldiv_op_if.sv ====
`timescale 1ns/1ps

interface muldiv_op_if;
	import muldiv_pkg::*;

	logic    start; // One-cycle pulse, only while busy is low
	funct3_t funct3;
	data_t   a;
	data_t   b;
	logic    busy;
	logic    done; // One-cycle pulse with result valid
	data_t   result;

	modport ctrl (
		output start,
		output funct3,
		output a,
		output b,
		input  busy,
		input  done,
		input  result
	);

	modport unit (
		input  start,
		input  funct3,
		input  a,
		input  b,
		output busy,
		output done,
		output result
	);

endinterface

// ==== source/muldiv_pkg.sv ====
`include "muldiv_params.svh"

package muldiv_pkg;

	typedef logic [`MULDIV_XLEN-1:0] data_t;

	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} funct3_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_t;

	localparam logic [6:0] OPCODE_OP     = 7'b0110011; // Register-register ALU group
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // Selects the M extension

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

endpackage

// ==== include/muldiv_params.svh ====
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// Datapath width of one RV32 register
`define MULDIV_XLEN 32

`define MULDIV_ADDR_W 5

`define MULDIV_REG_OPA    5'h00 // Dividend or multiplicand, read-write
`define MULDIV_REG_OPB    5'h04 // Divisor or multiplier, read-write
`define MULDIV_REG_CMD    5'h08 // R-type instruction word, write-only
`define MULDIV_REG_RESULT 5'h0C
`define MULDIV_REG_STATUS 5'h10 // Bit 0 busy, bit 1 done, bit 2 illegal

`define MULDIV_STATUS_BUSY    0
`define MULDIV_STATUS_DONE    1
`define MULDIV_STATUS_ILLEGAL 2

`endif
